// ==== tb.f ====
+incdir+tb
verilog/filter_pkg.sv
verilog/pixel_window.sv
verilog/blur_kernel.sv
verilog/edge_kernel.sv
verilog/output_select.sv
verilog/blur_filter.sv
tb/tb_blur_filter.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the blur filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_blur_filter -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb/filter_model.svh ====
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// Window entries are whole pixels, index 0 is the oldest

function automatic int channel_value(input logic [PIX_BITS-1:0] pix, input int lsb);
    return int'(pix[lsb +: CH_BITS]);
endfunction

function automatic logic [PIX_BITS-1:0] blur_model(input logic [PIX_BITS-1:0] win [WIN_TAPS]);
    logic [PIX_BITS-1:0] result;
    int sum;
    result = '0;
    for (int lsb = 0; lsb < PIX_BITS; lsb += CH_BITS) begin
        sum = 0;
        for (int r = 0; r < WIN_ROWS; r++) begin
            for (int k = 0; k < WIN_COLS; k++) begin
                sum += channel_value(win[r * IMG_WIDTH + k], lsb)
                       * int'(BLUR_WEIGHT[r * WIN_COLS + k]);
            end
        end
        result[lsb +: CH_BITS] = CH_BITS'(sum / 64);
    end
    return result;
endfunction

// Left edge on red, white when the sum is 16 or more, or negative
function automatic logic [PIX_BITS-1:0] edge_model(input logic [PIX_BITS-1:0] win [WIN_TAPS]);
    int sum;
    sum = 0;
    for (int r = 0; r < 3; r++) begin
        for (int k = 0; k < 5; k++) begin
            sum += channel_value(win[(r + 2) * IMG_WIDTH + k + 2], RED_LSB)
                   * EDGE_WEIGHT[r * 5 + k];
        end
    end
    return (sum >= 16 || sum < 0) ? PIX_WHITE : PIX_BLACK;
endfunction

`endif

// ==== tb/tb_blur_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_blur_filter;

    import filter_pkg::*;

    `include "filter_model.svh"

    localparam int FRAME_PIX   = 4 * IMG_WIDTH + 8;
    localparam int FRAMES      = 4;
    localparam int CYCLE_LIMIT = 4 * (FRAMES * FRAME_PIX * 3) + 200;

    logic clk = 1'b0;
    logic rst;
    logic valid_in;
    logic ready_in;
    logic sop_in;
    logic eop_in;
    logic [1:0] mode;
    logic [PIX_BITS-1:0] data_in;
    logic ready_out;
    logic valid_out;
    logic sop_out;
    logic eop_out;
    logic [PIX_BITS-1:0] data_out;

    int seed = 32'h0a12b521;
    int mismatch_count = 0;
    int other_count = 0;
    int accept_count = 0;
    int strobe_count = 0;
    int cycle_count = 0;

    logic [PIX_BITS-1:0] model_win [WIN_TAPS];
    logic [PIX_BITS+1:0] exp_q [$];
    logic [PIX_BITS-1:0] next_pix;
    logic [PIX_BITS-1:0] head_data;
    logic head_sop;
    logic head_eop;
    // Values seen at the last rising edge
    logic [PIX_BITS-1:0] held_data;
    logic ready_at_edge;
    logic rst_at_edge;

    blur_filter DUT (
        .clk               (clk),
        .rst               (rst),
        .valid_in          (valid_in),
        .ready_in          (ready_in),
        .startofpacket_in  (sop_in),
        .endofpacket_in    (eop_in),
        .mode              (mode),
        .data_in           (data_in),
        .ready_out         (ready_out),
        .valid_out         (valid_out),
        .startofpacket_out (sop_out),
        .endofpacket_out   (eop_out),
        .data_out          (data_out)
    );

    always #2 clk = ~clk;

    // Model window and expected results, one queue entry per accepted beat
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            for (int i = 0; i < WIN_TAPS; i++) begin
                model_win[i] = '0;
            end
        end else begin
            if (valid_out) begin
                strobe_count++;
                if (exp_q.size() == 0) begin
                    $display("time %0t: valid_out strobe without an accepted beat", $time);
                    other_count++;
                end else begin
                    void'(exp_q.pop_front());
                end
            end
            if (valid_in && ready_in) begin
                accept_count++;
                case (mode)
                    MODE_BLUR: next_pix = blur_model(model_win);
                    MODE_EDGE: next_pix = edge_model(model_win);
                    default:   next_pix = data_in;
                endcase
                exp_q.push_back({sop_in, eop_in, next_pix});
                for (int i = 0; i < WIN_TAPS - 1; i++) begin
                    model_win[i] = sop_in ? '0 : model_win[i + 1];
                end
                model_win[WIN_TAPS - 1] = data_in;
            end
        end
        if (exp_q.size() != 0) begin
            {head_sop, head_eop, head_data} = exp_q[0];
        end
        held_data     = data_out;
        ready_at_edge = ready_in;
        rst_at_edge   = rst;
    end

    // Outputs settle well before the falling edge
    a_reset_idle: assert property (@(negedge clk) (rst || rst_at_edge) |->
        (!valid_out && !sop_out && !eop_out && data_out == '0))
        else begin
            $display("time %0t: outputs not idle during or right after reset", $time);
            other_count++;
        end

    a_data: assert property (@(negedge clk) disable iff (rst) valid_out |-> data_out == head_data)
        else begin
            $display("MISMATCH time=%0t data_out expected=%h actual=%h", $time, head_data, data_out);
            mismatch_count++;
        end

    a_sop: assert property (@(negedge clk) disable iff (rst) valid_out |-> sop_out == head_sop)
        else begin
            $display("MISMATCH time=%0t startofpacket_out expected=%b actual=%b",
                     $time, head_sop, sop_out);
            mismatch_count++;
        end

    a_eop: assert property (@(negedge clk) disable iff (rst) valid_out |-> eop_out == head_eop)
        else begin
            $display("MISMATCH time=%0t endofpacket_out expected=%b actual=%b",
                     $time, head_eop, eop_out);
            mismatch_count++;
        end

    a_ready: assert property (@(negedge clk) ready_out == ready_in)
        else begin
            $display("MISMATCH time=%0t ready_out expected=%b actual=%b", $time, ready_in, ready_out);
            mismatch_count++;
        end

    a_stall_no_strobe: assert property (@(negedge clk) disable iff (rst) !ready_at_edge |-> !valid_out)
        else begin
            $display("time %0t: valid_out strobe while ready_in was low", $time);
            other_count++;
        end

    a_stall_hold: assert property (@(negedge clk) disable iff (rst)
        !ready_at_edge |-> data_out == held_data)
        else begin
            $display("MISMATCH time=%0t data_out expected=%h actual=%h", $time, held_data, data_out);
            mismatch_count++;
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic send_beat(input logic [PIX_BITS-1:0] pix, input logic sop, input logic eop);
        int stall;
        // Sometimes an idle cycle first, ready wanders meanwhile
        if (($random(seed) & 3) == 0) begin
            valid_in = 1'b0;
            ready_in = 1'($random(seed));
            @(posedge clk);
            #1;
        end
        stall = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 1) : 0;
        valid_in = 1'b1;
        data_in  = pix;
        sop_in   = sop;
        eop_in   = eop;
        repeat (stall) begin
            ready_in = 1'b0;
            @(posedge clk);
            #1;
        end
        ready_in = 1'b1;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic send_frame(input logic [PIX_BITS-1:0] base, input logic [PIX_BITS-1:0] mask);
        logic [PIX_BITS-1:0] pix;
        for (int i = 0; i < FRAME_PIX; i++) begin
            pix = base | (PIX_BITS'($random(seed)) & mask);
            send_beat(pix, i == 0, i == FRAME_PIX - 1);
        end
    endtask

    initial begin
        rst      = 1'b1;
        valid_in = 1'b0;
        ready_in = 1'b0;
        sop_in   = 1'b0;
        eop_in   = 1'b0;
        mode     = MODE_PASS;
        data_in  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        repeat (FRAMES) send_frame(12'h000, 12'hfff);
        mode = MODE_EDGE;
        repeat (FRAMES) send_frame(12'h000, 12'hfff);
        mode = MODE_BLUR;
        repeat (FRAMES - 2) send_frame(12'h000, 12'hfff);
        // Bright frame, then a dark one that must start from a cleared window
        send_frame(12'hccc, 12'h333);
        send_frame(12'h000, 12'h111);
        ready_in = 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        a_strobe_count: assert (strobe_count == accept_count)
            else begin
                $display("%0d valid_out strobes for %0d accepted beats", strobe_count, accept_count);
                other_count++;
            end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/blur_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module blur_filter (
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  logic ready_in,
    input  logic startofpacket_in,
    input  logic endofpacket_in,
    input  logic [1:0] mode,
    input  logic [filter_pkg::PIX_BITS-1:0] data_in,
    output logic ready_out,
    output logic valid_out,
    output logic startofpacket_out,
    output logic endofpacket_out,
    output logic [filter_pkg::PIX_BITS-1:0] data_out
);

    import filter_pkg::*;

    logic accept;
    logic [WIN_TAPS-1:0][CH_BITS-1:0] red_taps;
    logic [WIN_TAPS-1:0][CH_BITS-1:0] green_taps;
    logic [WIN_TAPS-1:0][CH_BITS-1:0] blue_taps;
    logic [PIX_BITS-1:0] blur_pixel;
    logic [PIX_BITS-1:0] edge_pixel;

    // Downstream ready goes straight upstream
    assign ready_out = ready_in;
    assign accept    = valid_in && ready_in;

    pixel_window u_window (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .sop_in     (startofpacket_in),
        .data_in    (data_in),
        .red_taps   (red_taps),
        .green_taps (green_taps),
        .blue_taps  (blue_taps)
    );

    blur_kernel u_blur (
        .red_taps   (red_taps),
        .green_taps (green_taps),
        .blue_taps  (blue_taps),
        .blur_pixel (blur_pixel)
    );

    edge_kernel u_edge (
        .red_taps   (red_taps),
        .edge_pixel (edge_pixel)
    );

    output_select u_select (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .mode       (mode),
        .data_in    (data_in),
        .blur_pixel (blur_pixel),
        .edge_pixel (edge_pixel),
        .sop_in     (startofpacket_in),
        .eop_in     (endofpacket_in),
        .valid_out  (valid_out),
        .sop_out    (startofpacket_out),
        .eop_out    (endofpacket_out),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

// ==== verilog/output_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_select (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  logic [1:0] mode,
    input  logic [filter_pkg::PIX_BITS-1:0] data_in,
    input  logic [filter_pkg::PIX_BITS-1:0] blur_pixel,
    input  logic [filter_pkg::PIX_BITS-1:0] edge_pixel,
    input  logic sop_in,
    input  logic eop_in,
    output logic valid_out,
    output logic sop_out,
    output logic eop_out,
    output logic [filter_pkg::PIX_BITS-1:0] data_out
);

    import filter_pkg::*;

    logic [PIX_BITS-1:0] sel_pixel;

    always_comb begin
        case (mode)
            MODE_PASS: sel_pixel = data_in;
            MODE_BLUR: sel_pixel = blur_pixel;
            MODE_EDGE: sel_pixel = edge_pixel;
            default:   sel_pixel = PIX_BLACK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            sop_out   <= 1'b0;
            eop_out   <= 1'b0;
            data_out  <= '0;
        end else begin
            valid_out <= accept;
            // Hold everything else between beats
            if (accept) begin
                sop_out  <= sop_in;
                eop_out  <= eop_in;
                data_out <= sel_pixel;
            end
        end
    end

    a_legal_mode: assert property (
        @(posedge clk) disable iff (rst) accept |-> (mode != 2'd3)
    ) else $error("output_select: illegal mode 3 on an accepted beat");

endmodule

`default_nettype wire

// ==== verilog/edge_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_kernel (
    input  logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] red_taps,
    output logic [filter_pkg::PIX_BITS-1:0] edge_pixel
);

    import filter_pkg::*;

    logic signed [EDGE_BITS-1:0] edge_sum;

    // Signed sum stays within +-120
    always_comb begin
        int acc;
        int idx;
        acc = 0;
        for (int r = 0; r < EDGE_ROWS; r++) begin
            for (int k = 0; k < EDGE_COLS; k++) begin
                idx = (EDGE_ROW0 + r) * IMG_WIDTH + EDGE_COL0 + k;
                acc += int'(red_taps[idx]) * EDGE_WEIGHT[r * EDGE_COLS + k];
            end
        end
        edge_sum = EDGE_BITS'(acc);
    end

    // Negative sums set the top bits too, so they also read as white
    assign edge_pixel = (edge_sum[EDGE_BITS-1:EDGE_THRESH_LSB] != '0) ? PIX_WHITE : PIX_BLACK;

endmodule

`default_nettype wire

// ==== verilog/blur_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module blur_kernel (
    input  logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] red_taps,
    input  logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] green_taps,
    input  logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] blue_taps,
    output logic [filter_pkg::PIX_BITS-1:0] blur_pixel
);

    import filter_pkg::*;

    logic [WIN_TAPS-1:0][CH_BITS-1:0] ch_taps [NUM_CH];
    logic [BLUR_BITS-1:0] ch_sum [NUM_CH];
    logic [CH_BITS-1:0] ch_out [NUM_CH];

    assign ch_taps[0] = red_taps;
    assign ch_taps[1] = green_taps;
    assign ch_taps[2] = blue_taps;

    always_comb begin
        int acc;
        for (int c = 0; c < NUM_CH; c++) begin
            acc = 0;
            for (int r = 0; r < WIN_ROWS; r++) begin
                for (int k = 0; k < WIN_COLS; k++) begin
                    acc += int'(ch_taps[c][r * IMG_WIDTH + k]) * BLUR_WEIGHT[r * WIN_COLS + k];
                end
            end
            ch_sum[c] = BLUR_BITS'(acc);
            ch_out[c] = CH_BITS'(ch_sum[c] >> BLUR_SHIFT);
        end
    end

    always_comb begin
        blur_pixel = '0;
        blur_pixel[RED_LSB +: CH_BITS]   = ch_out[0];
        blur_pixel[GREEN_LSB +: CH_BITS] = ch_out[1];
        blur_pixel[BLUE_LSB +: CH_BITS]  = ch_out[2];
    end

endmodule

`default_nettype wire

// ==== verilog/pixel_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_window (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  logic sop_in,
    input  logic [filter_pkg::PIX_BITS-1:0] data_in,
    output logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] red_taps,
    output logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] green_taps,
    output logic [filter_pkg::WIN_TAPS-1:0][filter_pkg::CH_BITS-1:0] blue_taps
);

    import filter_pkg::*;

    logic [CH_BITS-1:0] ch_in [NUM_CH];
    logic [WIN_TAPS-1:0][CH_BITS-1:0] taps [NUM_CH];

    // Channel order is red, green, blue
    assign ch_in[0] = data_in[RED_LSB +: CH_BITS];
    assign ch_in[1] = data_in[GREEN_LSB +: CH_BITS];
    assign ch_in[2] = data_in[BLUE_LSB +: CH_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                taps[c] <= '0;
            end
        end else if (accept) begin
            for (int c = 0; c < NUM_CH; c++) begin
                // New pixel enters the top, everything moves toward tap 0
                if (sop_in) begin
                    taps[c] <= {ch_in[c], {((WIN_TAPS - 1) * CH_BITS){1'b0}}};
                end else begin
                    taps[c] <= {ch_in[c], taps[c][WIN_TAPS-1:1]};
                end
            end
        end
    end

    assign red_taps   = taps[0];
    assign green_taps = taps[1];
    assign blue_taps  = taps[2];

    // First beat out of reset must not be a start of packet
    a_no_sop_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !(accept && sop_in)
    ) else $error("pixel_window: sop accepted in the first cycle after reset");

endmodule

`default_nettype wire

// ==== verilog/filter_pkg.sv ====
`default_nettype none

package filter_pkg;

    // Image and window geometry
    localparam int IMG_WIDTH = 8;
    localparam int WIN_ROWS  = 5;
    localparam int WIN_COLS  = 7;
    // Four line strides plus one window row, tap 0 is the oldest pixel
    localparam int WIN_TAPS  = 4 * IMG_WIDTH + WIN_COLS;

    // Pixel layout, RGB 4:4:4
    localparam int NUM_CH    = 3;
    localparam int CH_BITS   = 4;
    localparam int PIX_BITS  = NUM_CH * CH_BITS;
    localparam int RED_LSB   = 8;
    localparam int GREEN_LSB = 4;
    localparam int BLUE_LSB  = 0;

    localparam logic [PIX_BITS-1:0] PIX_WHITE = '1;
    localparam logic [PIX_BITS-1:0] PIX_BLACK = '0;

    // Blur weights sum to 64
    localparam int BLUR_BITS  = 10;
    localparam int BLUR_SHIFT = 6;
    localparam int unsigned BLUR_WEIGHT [WIN_ROWS * WIN_COLS] = '{
        0, 0, 1, 1, 1, 2, 2,
        0, 1, 1, 1, 2, 2, 2,
        1, 1, 1, 2, 2, 2, 4,
        1, 1, 2, 2, 2, 4, 4,
        1, 2, 2, 2, 4, 4, 4
    };

    // Left edge operator over window rows 2..4, columns 2..6
    localparam int EDGE_ROW0 = 2;
    localparam int EDGE_COL0 = 2;
    localparam int EDGE_ROWS = 3;
    localparam int EDGE_COLS = 5;
    localparam int EDGE_BITS = 8;
    // White when any bit from here up is set
    localparam int EDGE_THRESH_LSB = 4;
    localparam int EDGE_WEIGHT [EDGE_ROWS * EDGE_COLS] = '{
        1, 1, 0, -1, -1,
        2, 2, 0, -2, -2,
        1, 1, 0, -1, -1
    };

    // Mode codes, 3 is illegal
    localparam logic [1:0] MODE_PASS = 2'd0;
    localparam logic [1:0] MODE_BLUR = 2'd1;
    localparam logic [1:0] MODE_EDGE = 2'd2;

endpackage

`default_nettype wire
